/* project.f */
logic/core_pkg.sv
logic/mem_bus_pkg.sv
logic/sync_fifo.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/mem_arbiter.sv
logic/mem_front_end.sv
test/clock_gen.sv
test/tb_mem_front_end.sv

/* Makefile */
SIM  := obj_dir/Vtb_mem_front_end
SRCS := $(wildcard logic/*.sv test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): project.f $(SRCS)
	verilator --binary --timing -f project.f --top-module tb_mem_front_end

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* test/tb_mem_front_end.sv */
// Testbench for the memory front end
// Memory model with refusals, rotating tags and out-of-order replies,
// a reference for the fetch stream and load data, and one compare process
`timescale 1ns/1ps

module tb_mem_front_end import core_pkg::*, mem_bus_pkg::*; ();

  // Cycles allowed for any single wait
  localparam int wait_limit  = 2000;
  // Reply latency range of the memory model
  localparam int min_latency = 1;
  localparam int max_latency = 6;

  logic          clock;
  logic          reset;
  redirect_t     redirect;
  fetch_packet_t fetch_out;
  logic          fetch_valid;
  logic          fetch_ready;
  data_req_t     data_req;
  logic          data_req_valid;
  logic          data_req_ready;
  load_result_t  load_out;
  logic          load_valid;
  logic          load_ready;
  bus_request_t  proc2mem;
  mem_tag_t      mem2proc_response;
  bus_reply_t    mem2proc;

  int seed = 25731;

  // Memory model state
  data_t      model_map [addr_t];
  logic       tag_busy [num_tags];
  bus_reply_t reply_q [$];
  int         reply_due [$];
  int         mem_cycle;
  int         next_tag;
  int         refuse_count;
  logic       in_reset;

  // Reference state
  data_t         ref_map [addr_t];
  load_result_t  expected_loads [$];
  addr_t         expect_pc;
  logic          target_pending;
  addr_t         target_addr;
  fetch_packet_t want_fetch;
  load_result_t  want_load;

  // Bookkeeping
  int   error_count;
  int   test_count;
  int   test_start_errors;
  int   fetch_count;
  int   load_count;
  logic timed_out;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  mem_front_end u_mem_front_end (
    .clock             (clock),
    .reset             (reset),
    .redirect          (redirect),
    .fetch_out         (fetch_out),
    .fetch_valid       (fetch_valid),
    .fetch_ready       (fetch_ready),
    .data_req          (data_req),
    .data_req_valid    (data_req_valid),
    .data_req_ready    (data_req_ready),
    .load_out          (load_out),
    .load_valid        (load_valid),
    .load_ready        (load_ready),
    .proc2mem          (proc2mem),
    .mem2proc_response (mem2proc_response),
    .mem2proc          (mem2proc)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Initial memory content, every address bit takes part
  function automatic data_t word_at(addr_t addr);
    data_t mix;
    mix = addr * 64'h9e37_79b9_7f4a_7c15;
    return mix ^ {addr[31:0], addr[63:32]} ^ 64'h0f1e_2d3c_4b5a_6978;
  endfunction

  // Bit 2 of the pc picks the upper half
  function automatic inst_t expected_inst(addr_t pc);
    data_t word;
    word = word_at({pc[63:3], 3'b000});
    return pc[2] ? word[63:32] : word[31:0];
  endfunction

  // Stores seen so far override the initial content
  function automatic data_t expected_load(addr_t addr);
    return ref_map.exists(addr) ? ref_map[addr] : word_at(addr);
  endfunction

  function automatic data_t model_word(addr_t addr);
    return model_map.exists(addr) ? model_map[addr] : word_at(addr);
  endfunction

  ////////////////////
  // Memory model
  ////////////////////
  task automatic memory_cycle();
    mem_tag_t   free_tag;
    bus_reply_t entry;
    int         cand;
    int         pick;
    free_tag = no_tag;
    pick = -1;
    mem_cycle++;
    mem2proc_response = no_tag;
    if (proc2mem.cmd != bus_none)
    begin
      // Rotating search over tags 1 to 15
      for (int i = 0; i < num_tags - 1; i++)
      begin
        cand = ((next_tag + i) % (num_tags - 1)) + 1;
        if (free_tag == no_tag && !tag_busy[cand])
          free_tag = mem_tag_t'(cand);
      end
      if ((($random(seed) & 3) == 0) || (free_tag == no_tag))
        refuse_count++;
      else
      begin
        mem2proc_response = free_tag;
        next_tag++;
        if (proc2mem.cmd == bus_store)
          model_map[proc2mem.addr] = proc2mem.data;
        else
        begin
          tag_busy[free_tag] = 1'b1;
          entry.tag  = free_tag;
          entry.data = model_word(proc2mem.addr);
          reply_q.push_back(entry);
          reply_due.push_back(mem_cycle + min_latency +
            int'($unsigned($random(seed)) % (max_latency - min_latency + 1)));
        end
      end
    end
    // First due reply goes out, so replies may pass each other
    for (int i = 0; i < reply_q.size(); i++)
    begin
      if (pick < 0 && reply_due[i] <= mem_cycle)
        pick = i;
    end
    if (pick >= 0)
    begin
      mem2proc = reply_q[pick];
      tag_busy[reply_q[pick].tag] = 1'b0;
      reply_q.delete(pick);
      reply_due.delete(pick);
    end
    else
      mem2proc = '0;
  endtask

  always @(posedge clock)
  begin
    in_reset = reset;
    #1;
    if (in_reset !== 1'b0)
    begin
      mem2proc_response = no_tag;
      mem2proc = '0;
      reply_q.delete();
      reply_due.delete();
      for (int i = 0; i < num_tags; i++)
        tag_busy[i] = 1'b0;
    end
    else
      memory_cycle();
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_fetch(string name, fetch_packet_t got, fetch_packet_t want);
    if (got !== want)
    begin
      error_count++;
      $display("error %s: pc %h inst %h, expected pc %h inst %h",
               name, got.pc, got.inst, want.pc, want.inst);
    end
  endtask

  task automatic check_load(string name, load_result_t got, load_result_t want);
    if (got !== want)
    begin
      error_count++;
      $display("error %s: addr %h data %h, expected addr %h data %h",
               name, got.addr, got.data, want.addr, want.data);
    end
  endtask

  task automatic check_cmd(string name, bus_cmd_t got, bus_cmd_t want);
    if (got !== want)
    begin
      error_count++;
      $display("error %s: got %h, expected %h", name, got, want);
    end
  endtask

  task automatic check_flag(string name, logic got, logic want);
    if (got !== want)
    begin
      error_count++;
      $display("error %s: got %h, expected %h", name, got, want);
    end
  endtask

  // Outputs sampled mid-cycle, a transfer lands on the next rising edge
  always @(negedge clock)
  begin
    if (reset === 1'b0)
    begin
      if (fetch_valid && fetch_ready)
      begin
        // First target packet ends the old path
        if (target_pending && fetch_out.pc == target_addr)
        begin
          expect_pc = target_addr;
          target_pending = 1'b0;
        end
        want_fetch.pc   = expect_pc;
        want_fetch.inst = expected_inst(expect_pc);
        check_fetch("fetch_out", fetch_out, want_fetch);
        expect_pc = expect_pc + 64'd4;
        fetch_count++;
      end
      if (load_valid && load_ready)
      begin
        if (expected_loads.size() == 0)
        begin
          error_count++;
          $display("a load result came out with no load outstanding");
        end
        else
        begin
          want_load = expected_loads.pop_front();
          check_load("load_out", load_out, want_load);
        end
        load_count++;
      end
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic report_timeout(string what);
    error_count++;
    timed_out = 1'b1;
    $display("timeout: %s did not happen within %0d cycles", what, wait_limit);
  endtask

  task automatic present_req(data_req_t req);
    data_req       = req;
    data_req_valid = 1'b1;
  endtask

  // Holds the request until ready, then updates the reference
  task automatic complete_req(data_req_t req);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < wait_limit)
    begin
      @(negedge clock);
      seen = data_req_ready;
      waited++;
    end
    if (!seen)
    begin
      report_timeout("data request handshake");
      data_req_valid = 1'b0;
      return;
    end
    if (req.store)
      ref_map[req.addr] = req.data;
    else
    begin
      want_load.addr = req.addr;
      want_load.data = expected_load(req.addr);
      expected_loads.push_back(want_load);
    end
    next_cycle();
    data_req_valid = 1'b0;
  endtask

  task automatic send_data_req(logic store, addr_t addr, data_t data);
    data_req_t req;
    req.store = store;
    req.addr  = addr;
    req.data  = data;
    present_req(req);
    complete_req(req);
  endtask

  task automatic redirect_to(addr_t target);
    target_addr     = target;
    target_pending  = 1'b1;
    redirect.valid  = 1'b1;
    redirect.target = target;
    next_cycle();
    redirect = '0;
  endtask

  task automatic await_packets(int total);
    int waited;
    waited = 0;
    while (fetch_count < total && waited < wait_limit)
    begin
      next_cycle();
      waited++;
    end
    if (fetch_count < total)
      report_timeout("fetch packet delivery");
  endtask

  task automatic await_target();
    int waited;
    waited = 0;
    while (target_pending && waited < wait_limit)
    begin
      next_cycle();
      waited++;
    end
    if (target_pending)
      report_timeout("first packet at the redirect target");
  endtask

  task automatic drain_loads();
    int waited;
    waited = 0;
    while (expected_loads.size() != 0 && waited < wait_limit)
    begin
      next_cycle();
      waited++;
    end
    if (expected_loads.size() != 0)
      report_timeout("return of all load results");
  endtask

  task automatic begin_test();
    test_start_errors = error_count;
  endtask

  task automatic end_test(string name);
    int errs;
    errs = error_count - test_start_errors;
    test_count++;
    if (errs == 0)
      $display("test %0d %s: passed", test_count, name);
    else
      $display("test %0d %s: failed with %0d errors", test_count, name, errs);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  // Idle outputs while reset is held
  task automatic reset_state();
    begin_test();
    repeat (2) @(posedge clock);
    @(negedge clock);
    check_cmd("proc2mem.cmd", proc2mem.cmd, bus_none);
    check_flag("fetch_valid", fetch_valid, 1'b0);
    check_flag("load_valid", load_valid, 1'b0);
    check_flag("data_req_ready", data_req_ready, 1'b1);
    end_test("state during reset");
  endtask

  task automatic stream_after_reset();
    begin_test();
    fetch_ready = 1'b1;
    await_packets(fetch_count + 40);
    end_test("fetch stream after reset");
  endtask

  // Long stalls with short bursts in between
  task automatic stalled_stream();
    int burst;
    begin_test();
    for (int i = 0; i < 8; i++)
    begin
      fetch_ready = 1'b0;
      repeat (25) next_cycle();
      fetch_ready = 1'b1;
      burst = 1 + int'($unsigned($random(seed)) % 4);
      repeat (burst) next_cycle();
    end
    await_packets(fetch_count + 10);
    end_test("fetch stream with stalls");
  endtask

  task automatic redirect_stream();
    begin_test();
    fetch_ready = 1'b1;
    redirect_to(64'h0000_0000_0000_0804);
    await_target();
    await_packets(fetch_count + 12);
    // Second redirect with a full queue of old packets
    fetch_ready = 1'b0;
    repeat (12) next_cycle();
    redirect_to(64'h0000_0000_0000_0300);
    repeat (6) next_cycle();
    fetch_ready = 1'b1;
    await_target();
    await_packets(fetch_count + 12);
    end_test("redirect");
  endtask

  task automatic random_loads();
    addr_t addr;
    begin_test();
    load_ready = 1'b1;
    for (int i = 0; i < 12 && !timed_out; i++)
    begin
      addr = {$random(seed), $random(seed)};
      addr[2:0] = 3'b000;
      send_data_req(1'b0, addr, '0);
    end
    drain_loads();
    end_test("random loads");
  endtask

  task automatic store_then_load();
    addr_t addr;
    data_t data;
    int    refusals_before;
    begin_test();
    refusals_before = refuse_count;
    for (int i = 0; i < 8 && !timed_out; i++)
    begin
      addr = 64'h0000_0000_0002_0000 + 64'(i * 24);
      data = {$random(seed), $random(seed)};
      send_data_req(1'b1, addr, data);
    end
    for (int i = 7; i >= 0 && !timed_out; i--)
      send_data_req(1'b0, 64'h0000_0000_0002_0000 + 64'(i * 24), '0);
    // Overwrite then read back straight away
    for (int i = 0; i < 6 && !timed_out; i++)
    begin
      addr = 64'h0000_0000_0002_0000 + 64'(i * 24);
      data = {$random(seed), $random(seed)};
      send_data_req(1'b1, addr, data);
      send_data_req(1'b0, addr, '0);
    end
    drain_loads();
    if (refuse_count == refusals_before)
    begin
      error_count++;
      $display("the memory refused no request during the store and load test");
    end
    end_test("stores then loads");
  endtask

  task automatic load_backpressure();
    data_req_t third;
    begin_test();
    load_ready = 1'b0;
    send_data_req(1'b0, 64'h0000_0000_0002_0000, '0);
    send_data_req(1'b0, 64'h0000_0000_0002_0018, '0);
    third.store = 1'b0;
    third.addr  = 64'h0000_0000_0002_0030;
    third.data  = '0;
    present_req(third);
    // Queue fills while results are held back
    for (int i = 0; i < 30; i++)
    begin
      @(negedge clock);
      if (data_req_ready)
      begin
        error_count++;
        $display("data_req_ready went high while the load queue was held full");
        break;
      end
    end
    if (!load_valid)
    begin
      error_count++;
      $display("no load result was waiting while load_ready was low");
    end
    next_cycle();
    load_ready = 1'b1;
    complete_req(third);
    drain_loads();
    end_test("load queue back-pressure");
  endtask

  task automatic run_tests();
    stream_after_reset();
    if (timed_out)
      return;
    stalled_stream();
    if (timed_out)
      return;
    redirect_stream();
    if (timed_out)
      return;
    random_loads();
    if (timed_out)
      return;
    store_then_load();
    if (timed_out)
      return;
    load_backpressure();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin : main
    int waited;
    redirect          = '0;
    fetch_ready       = 1'b0;
    data_req          = '0;
    data_req_valid    = 1'b0;
    load_ready        = 1'b0;
    mem2proc_response = no_tag;
    mem2proc          = '0;
    mem_cycle         = 0;
    next_tag          = 0;
    refuse_count      = 0;
    expect_pc         = '0;
    target_pending    = 1'b0;
    target_addr       = '0;
    error_count       = 0;
    test_count        = 0;
    fetch_count       = 0;
    load_count        = 0;
    timed_out         = 1'b0;

    reset_state();

    waited = 0;
    while (reset !== 1'b0 && waited < wait_limit)
    begin
      @(posedge clock);
      waited++;
    end
    if (reset !== 1'b0)
      report_timeout("release of reset");
    else
    begin
      next_cycle();
      run_tests();
    end

    $display("tests %0d, errors %0d, fetch packets %0d, load results %0d, refusals %0d",
             test_count, error_count, fetch_count, load_count, refuse_count);
    if (error_count == 0 && !timed_out)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

/* test/clock_gen.sv */
// Clock and reset source for the testbench
// 4 ns clock, reset held high for the first 8 rising edges
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Released just after the eighth edge, like any other input
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

/* logic/mem_front_end.sv */
// Memory front end, top level
// Fetch and load/store share one memory port through the arbiter;
// fetched packets and load results leave through their own queues
`timescale 1ns/1ps

module mem_front_end import core_pkg::*, mem_bus_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  redirect_t     redirect,
  output fetch_packet_t fetch_out,
  output logic          fetch_valid,
  input  logic          fetch_ready,
  input  data_req_t     data_req,
  input  logic          data_req_valid,
  output logic          data_req_ready,
  output load_result_t  load_out,
  output logic          load_valid,
  input  logic          load_ready,
  output bus_request_t  proc2mem,
  input  mem_tag_t      mem2proc_response,
  input  bus_reply_t    mem2proc
);

  // Fetch path
  bus_request_t  fetch_req;
  logic          fetch_req_valid;
  logic          fetch_accepted;
  logic          fetch_reply_valid;
  fetch_packet_t fetch_packet;
  logic          fetch_push;
  logic          fetch_full;

  // Data path
  bus_request_t  lsu_req;
  logic          lsu_req_valid;
  logic          lsu_accepted;
  logic          lsu_reply_valid;
  load_result_t  load_result;
  logic          load_push;
  logic          load_full;

  // Shared reply data
  data_t         reply_data;

  ////////////////////
  // Requesters
  ////////////////////
  fetch_unit u_fetch_unit (
    .clock             (clock),
    .reset             (reset),
    .redirect          (redirect),
    .fetch_req         (fetch_req),
    .fetch_req_valid   (fetch_req_valid),
    .fetch_accepted    (fetch_accepted),
    .fetch_reply_valid (fetch_reply_valid),
    .fetch_reply_data  (reply_data),
    .queue_full        (fetch_full),
    .packet            (fetch_packet),
    .packet_push       (fetch_push)
  );

  load_store_unit u_load_store_unit (
    .clock           (clock),
    .reset           (reset),
    .data_req        (data_req),
    .data_req_valid  (data_req_valid),
    .data_req_ready  (data_req_ready),
    .lsu_req         (lsu_req),
    .lsu_req_valid   (lsu_req_valid),
    .lsu_accepted    (lsu_accepted),
    .lsu_reply_valid (lsu_reply_valid),
    .lsu_reply_data  (reply_data),
    .queue_full      (load_full),
    .result          (load_result),
    .result_push     (load_push)
  );

  ////////////////////
  // Memory port
  ////////////////////
  mem_arbiter u_mem_arbiter (
    .clock             (clock),
    .reset             (reset),
    .fetch_req         (fetch_req),
    .fetch_req_valid   (fetch_req_valid),
    .fetch_accepted    (fetch_accepted),
    .fetch_reply_valid (fetch_reply_valid),
    .lsu_req           (lsu_req),
    .lsu_req_valid     (lsu_req_valid),
    .lsu_accepted      (lsu_accepted),
    .lsu_reply_valid   (lsu_reply_valid),
    .reply_data        (reply_data),
    .proc2mem          (proc2mem),
    .mem2proc_response (mem2proc_response),
    .mem2proc          (mem2proc)
  );

  ////////////////////
  // Output queues
  ////////////////////
  sync_fifo #(
    .item_t (fetch_packet_t),
    .depth  (fetch_depth)
  ) u_fetch_queue (
    .clock     (clock),
    .reset     (reset),
    .push      (fetch_push),
    .push_item (fetch_packet),
    .full      (fetch_full),
    .pop_valid (fetch_valid),
    .pop_ready (fetch_ready),
    .pop_item  (fetch_out)
  );

  sync_fifo #(
    .item_t (load_result_t),
    .depth  (load_depth)
  ) u_load_queue (
    .clock     (clock),
    .reset     (reset),
    .push      (load_push),
    .push_item (load_result),
    .full      (load_full),
    .pop_valid (load_valid),
    .pop_ready (load_ready),
    .pop_item  (load_out)
  );

endmodule

/* logic/mem_arbiter.sv */
// Memory port arbiter
// Data requests win over fetch; each accepted load tag remembers
// its requester so the reply can be steered back
`timescale 1ns/1ps

module mem_arbiter import core_pkg::*, mem_bus_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  bus_request_t fetch_req,
  input  logic         fetch_req_valid,
  output logic         fetch_accepted,
  output logic         fetch_reply_valid,
  input  bus_request_t lsu_req,
  input  logic         lsu_req_valid,
  output logic         lsu_accepted,
  output logic         lsu_reply_valid,
  output data_t        reply_data,
  output bus_request_t proc2mem,
  input  mem_tag_t     mem2proc_response,
  input  bus_reply_t   mem2proc
);

  // Tag owner table
  logic       owner_valid [num_tags];
  requester_t owner       [num_tags];

  requester_t grant;
  logic       accepted;
  logic       reply_hit;

  ////////////////////
  // Request select
  ////////////////////
  assign grant = lsu_req_valid ? req_data : req_fetch;

  always_comb
  begin
    proc2mem = '{cmd: bus_none, addr: '0, data: '0};
    if (lsu_req_valid)
      proc2mem = lsu_req;
    else if (fetch_req_valid)
      proc2mem = fetch_req;
  end

  // Nonzero response tag means taken
  assign accepted       = (proc2mem.cmd != bus_none) && (mem2proc_response != no_tag);
  assign lsu_accepted   = accepted && (grant == req_data);
  assign fetch_accepted = accepted && (grant == req_fetch);

  ////////////////////
  // Reply routing
  ////////////////////
  assign reply_hit         = (mem2proc.tag != no_tag) && owner_valid[mem2proc.tag];
  assign fetch_reply_valid = reply_hit && (owner[mem2proc.tag] == req_fetch);
  assign lsu_reply_valid   = reply_hit && (owner[mem2proc.tag] == req_data);
  assign reply_data        = mem2proc.data;

  // Owner written at the accepting edge
  always_ff @(posedge clock)
  begin
    if (accepted && (proc2mem.cmd == bus_load))
      owner[mem2proc_response] <= grant;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_tags; i++)
        owner_valid[i] <= 1'b0;
    end
    else
    begin
      // Clear first so a tag freed and reissued in one cycle stays valid
      if (reply_hit)
        owner_valid[mem2proc.tag] <= 1'b0;
      // Store tags get no reply, never recorded
      if (accepted && (proc2mem.cmd == bus_load))
        owner_valid[mem2proc_response] <= 1'b1;
    end
  end

endmodule

/* logic/load_store_unit.sv */
// Load/store unit
// Holds one data request until memory takes it; stores end there,
// loads wait for the reply and push address plus data to the queue
`timescale 1ns/1ps

module load_store_unit import core_pkg::*, mem_bus_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  data_req_t    data_req,
  input  logic         data_req_valid,
  output logic         data_req_ready,
  output bus_request_t lsu_req,
  output logic         lsu_req_valid,
  input  logic         lsu_accepted,
  input  logic         lsu_reply_valid,
  input  data_t        lsu_reply_data,
  input  logic         queue_full,
  output load_result_t result,
  output logic         result_push
);

  // Payload of the current request
  data_req_t held_req;
  // Waiting for the memory to accept
  logic      held;
  // Load accepted, reply outstanding
  logic      waiting;

  // Room in the queue reserved before taking a request
  assign data_req_ready = !held && !waiting && !queue_full;

  ////////////////////
  // Bus request
  ////////////////////
  assign lsu_req_valid = held;
  assign lsu_req.cmd   = held_req.store ? bus_store : bus_load;
  assign lsu_req.addr  = held_req.addr;
  assign lsu_req.data  = held_req.data;

  // Load result
  assign result.addr = held_req.addr;
  assign result.data = lsu_reply_data;
  assign result_push = lsu_reply_valid && waiting;

  always_ff @(posedge clock)
  begin
    if (data_req_valid && data_req_ready)
      held_req <= data_req;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      held    <= 1'b0;
      waiting <= 1'b0;
    end
    else
    begin
      if (data_req_valid && data_req_ready)
        held <= 1'b1;
      else if (lsu_accepted)
        held <= 1'b0;

      // Stores are done at acceptance
      if (lsu_accepted && !held_req.store)
        waiting <= 1'b1;
      else if (lsu_reply_valid)
        waiting <= 1'b0;
    end
  end

endmodule

/* logic/fetch_unit.sv */
// Instruction fetch unit
// Walks the program counter, one doubleword request at a time,
// picks the addressed half of each reply and restarts on redirect
`timescale 1ns/1ps

module fetch_unit import core_pkg::*, mem_bus_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  redirect_t     redirect,
  output bus_request_t  fetch_req,
  output logic          fetch_req_valid,
  input  logic          fetch_accepted,
  input  logic          fetch_reply_valid,
  input  data_t         fetch_reply_data,
  input  logic          queue_full,
  output fetch_packet_t packet,
  output logic          packet_push
);

  addr_t pc;
  // Request accepted, reply not yet seen
  logic  pending;
  // Outstanding reply belongs to the old path
  logic  stale;

  ////////////////////
  // Request side
  ////////////////////

  // Queue room checked here, so the reply always fits
  // No request while reset is held, the port stays idle
  assign fetch_req_valid = !reset && !pending && !queue_full;
  assign fetch_req.cmd   = bus_load;
  assign fetch_req.addr  = {pc[addr_width-1:3], 3'b000};
  assign fetch_req.data  = '0;

  ////////////////////
  // Reply side
  ////////////////////

  // Bit 2 picks the upper word
  assign packet.pc   = pc;
  assign packet.inst = pc[2] ? fetch_reply_data[63:32] : fetch_reply_data[31:0];

  // A reply racing a redirect is from the old path too
  assign packet_push = fetch_reply_valid && !stale && !redirect.valid;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      pc      <= '0;
      pending <= 1'b0;
      stale   <= 1'b0;
    end
    else
    begin
      if (redirect.valid)
        pc <= redirect.target;
      else if (packet_push)
        pc <= pc + addr_t'(4);

      if (fetch_accepted)
        pending <= 1'b1;
      else if (fetch_reply_valid)
        pending <= 1'b0;

      // Mark an in-flight request so its reply is dropped
      if (redirect.valid && (pending || fetch_accepted) && !fetch_reply_valid)
        stale <= 1'b1;
      else if (fetch_reply_valid)
        stale <= 1'b0;
    end
  end

endmodule

/* logic/sync_fifo.sv */
// Synchronous FIFO
// Circular buffer with a count, item type set per instance
`timescale 1ns/1ps

module sync_fifo #(
  parameter type item_t = logic,
  parameter int  depth  = 2
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  push,
  input  item_t push_item,
  output logic  full,
  output logic  pop_valid,
  input  logic  pop_ready,
  output item_t pop_item
);

  localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  item_t                  mem [depth];
  logic [ptr_width-1:0]   rd_ptr;
  logic [ptr_width-1:0]   wr_ptr;
  logic [count_width-1:0] count;
  logic                   do_push;
  logic                   do_pop;

  assign full      = (count == count_width'(depth));
  assign pop_valid = (count != '0);
  assign pop_item  = mem[rd_ptr];

  // Push into a full buffer is dropped
  assign do_push = push && !full;
  assign do_pop  = pop_valid && pop_ready;

  // Storage, written at the push edge
  always_ff @(posedge clock)
  begin
    if (do_push)
      mem[wr_ptr] <= push_item;
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // Pointers wrap at depth
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

/* logic/mem_bus_pkg.sv */
// Memory bus definitions
// Command encoding, tags, request and reply words,
// and the requester identity kept per outstanding tag
package mem_bus_pkg;

  ////////////////////
  // Commands and tags
  ////////////////////
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_cmd_t;

  typedef logic [3:0] mem_tag_t;

  // Tag zero never names a transaction
  localparam mem_tag_t no_tag = 4'h0;
  localparam int num_tags = 16;

  ////////////////////
  // Bus words
  ////////////////////

  // Processor to memory, one per cycle
  typedef struct packed {
    bus_cmd_t        cmd;
    core_pkg::addr_t addr;
    core_pkg::data_t data;
  } bus_request_t;

  // Memory to processor, tag nonzero on a load reply
  typedef struct packed {
    mem_tag_t        tag;
    core_pkg::data_t data;
  } bus_reply_t;

  // Owner of an outstanding tag
  typedef enum logic {
    req_fetch = 1'b0,
    req_data  = 1'b1
  } requester_t;

endpackage

/* logic/core_pkg.sv */
// Core-side definitions for the memory front end
// Widths, queue depths and the packets that move between
// the fetch path, the load/store path and the outside world
package core_pkg;

  ////////////////////
  // Widths and depths
  ////////////////////
  localparam int addr_width = 64;
  localparam int data_width = 64;
  localparam int inst_width = 32;

  // Fetch queue, one slot per packet
  localparam int fetch_depth = 4;
  // Load result queue
  localparam int load_depth = 2;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [inst_width-1:0] inst_t;

  ////////////////////
  // Packets
  ////////////////////

  // Branch redirect, target is word aligned
  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  // One fetched instruction with its pc
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_packet_t;

  // Data request from outside, address is doubleword aligned
  typedef struct packed {
    logic  store;
    addr_t addr;
    data_t data;
  } data_req_t;

  // Load result, returned in request order
  typedef struct packed {
    addr_t addr;
    data_t data;
  } load_result_t;

endpackage
